/* rtl/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // bus widths
    localparam int addr_w = 16;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;     // one strobe per byte
    localparam int resp_w = 2;

    // devices
    localparam int sram_words = 256;
    localparam int sram_idx_w = $clog2(sram_words);
    localparam int gpio_outputs = 4;

    // address map, bit 15 picks the region
    localparam int region_bit = 15;
    localparam logic [addr_w-1:0] sram_base = 16'h0000;
    localparam logic [addr_w-1:0] gpio_base = 16'h8000;

    // AXI response codes
    localparam logic [resp_w-1:0] resp_okay = 2'b00;
    localparam logic [resp_w-1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

/* rtl/axil_interconnect.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_interconnect
    import soc_pkg::*;
(
    input  logic clk,
    input  logic arst_n,

    // instruction-fetch master
    input  logic [addr_w-1:0] if_awaddr,
    input  logic if_awvalid,
    output logic if_awready,
    input  logic [data_w-1:0] if_wdata,
    input  logic [strb_w-1:0] if_wstrb,
    input  logic if_wvalid,
    output logic if_wready,
    output logic [resp_w-1:0] if_bresp,
    output logic if_bvalid,
    input  logic if_bready,
    input  logic [addr_w-1:0] if_araddr,
    input  logic if_arvalid,
    output logic if_arready,
    output logic [data_w-1:0] if_rdata,
    output logic [resp_w-1:0] if_rresp,
    output logic if_rvalid,
    input  logic if_rready,

    // data master
    input  logic [addr_w-1:0] d_awaddr,
    input  logic d_awvalid,
    output logic d_awready,
    input  logic [data_w-1:0] d_wdata,
    input  logic [strb_w-1:0] d_wstrb,
    input  logic d_wvalid,
    output logic d_wready,
    output logic [resp_w-1:0] d_bresp,
    output logic d_bvalid,
    input  logic d_bready,
    input  logic [addr_w-1:0] d_araddr,
    input  logic d_arvalid,
    output logic d_arready,
    output logic [data_w-1:0] d_rdata,
    output logic [resp_w-1:0] d_rresp,
    output logic d_rvalid,
    input  logic d_rready,

    // sram slave
    output logic [addr_w-1:0] sram_awaddr,
    output logic sram_awvalid,
    input  logic sram_awready,
    output logic [data_w-1:0] sram_wdata,
    output logic [strb_w-1:0] sram_wstrb,
    output logic sram_wvalid,
    input  logic sram_wready,
    input  logic [resp_w-1:0] sram_bresp,
    input  logic sram_bvalid,
    output logic sram_bready,
    output logic [addr_w-1:0] sram_araddr,
    output logic sram_arvalid,
    input  logic sram_arready,
    input  logic [data_w-1:0] sram_rdata,
    input  logic [resp_w-1:0] sram_rresp,
    input  logic sram_rvalid,
    output logic sram_rready,

    // gpio slave
    output logic [addr_w-1:0] gpio_awaddr,
    output logic gpio_awvalid,
    input  logic gpio_awready,
    output logic [data_w-1:0] gpio_wdata,
    output logic [strb_w-1:0] gpio_wstrb,
    output logic gpio_wvalid,
    input  logic gpio_wready,
    input  logic [resp_w-1:0] gpio_bresp,
    input  logic gpio_bvalid,
    output logic gpio_bready,
    output logic [addr_w-1:0] gpio_araddr,
    output logic gpio_arvalid,
    input  logic gpio_arready,
    input  logic [data_w-1:0] gpio_rdata,
    input  logic [resp_w-1:0] gpio_rresp,
    input  logic gpio_rvalid,
    output logic gpio_rready
);

    // grants are one-hot, bit 0 for if_, bit 1 for d_
    logic [1:0] wr_gnt;
    logic [1:0] rd_gnt;
    logic wr_last;
    logic rd_last;
    logic wr_tgt;                           // 1 selects gpio
    logic rd_tgt;
    logic wr_win;
    logic rd_win;
    logic wr_done;
    logic rd_done;

    logic [addr_w-1:0] m_awaddr;
    logic [addr_w-1:0] m_araddr;
    logic m_awvalid;
    logic m_wvalid;
    logic m_bready;
    logic m_arvalid;
    logic m_rready;
    logic s_awready;
    logic s_wready;
    logic s_bvalid;
    logic s_arready;
    logic s_rvalid;

    // round robin, the master not served last wins a tie
    function automatic logic pick(input logic if_req, input logic d_req, input logic last);
        if (if_req && d_req) begin
            return ~last;
        end
        return d_req;
    endfunction

    assign wr_win = pick(if_awvalid, d_awvalid, wr_last);
    assign rd_win = pick(if_arvalid, d_arvalid, rd_last);

    // granted master toward the slaves
    assign m_awaddr  = wr_gnt[1] ? d_awaddr : if_awaddr;
    assign m_awvalid = (wr_gnt[0] & if_awvalid) | (wr_gnt[1] & d_awvalid);
    assign m_wvalid  = (wr_gnt[0] & if_wvalid) | (wr_gnt[1] & d_wvalid);
    assign m_bready  = (wr_gnt[0] & if_bready) | (wr_gnt[1] & d_bready);
    assign m_araddr  = rd_gnt[1] ? d_araddr : if_araddr;
    assign m_arvalid = (rd_gnt[0] & if_arvalid) | (rd_gnt[1] & d_arvalid);
    assign m_rready  = (rd_gnt[0] & if_rready) | (rd_gnt[1] & d_rready);

    assign sram_awaddr  = m_awaddr;
    assign gpio_awaddr  = m_awaddr;
    assign sram_wdata   = wr_gnt[1] ? d_wdata : if_wdata;
    assign gpio_wdata   = sram_wdata;
    assign sram_wstrb   = wr_gnt[1] ? d_wstrb : if_wstrb;
    assign gpio_wstrb   = sram_wstrb;
    assign sram_awvalid = m_awvalid & ~wr_tgt;
    assign gpio_awvalid = m_awvalid & wr_tgt;
    assign sram_wvalid  = m_wvalid & ~wr_tgt;
    assign gpio_wvalid  = m_wvalid & wr_tgt;
    assign sram_bready  = m_bready & ~wr_tgt;
    assign gpio_bready  = m_bready & wr_tgt;

    assign sram_araddr  = m_araddr;
    assign gpio_araddr  = m_araddr;
    assign sram_arvalid = m_arvalid & ~rd_tgt;
    assign gpio_arvalid = m_arvalid & rd_tgt;
    assign sram_rready  = m_rready & ~rd_tgt;
    assign gpio_rready  = m_rready & rd_tgt;

    // selected slave back toward the masters
    assign s_awready = wr_tgt ? gpio_awready : sram_awready;
    assign s_wready  = wr_tgt ? gpio_wready : sram_wready;
    assign s_bvalid  = wr_tgt ? gpio_bvalid : sram_bvalid;
    assign s_arready = rd_tgt ? gpio_arready : sram_arready;
    assign s_rvalid  = rd_tgt ? gpio_rvalid : sram_rvalid;

    assign if_awready = wr_gnt[0] & s_awready;
    assign d_awready  = wr_gnt[1] & s_awready;
    assign if_wready  = wr_gnt[0] & s_wready;
    assign d_wready   = wr_gnt[1] & s_wready;
    assign if_bvalid  = wr_gnt[0] & s_bvalid;
    assign d_bvalid   = wr_gnt[1] & s_bvalid;
    assign if_bresp   = wr_tgt ? gpio_bresp : sram_bresp;
    assign d_bresp    = if_bresp;

    assign if_arready = rd_gnt[0] & s_arready;
    assign d_arready  = rd_gnt[1] & s_arready;
    assign if_rvalid  = rd_gnt[0] & s_rvalid;
    assign d_rvalid   = rd_gnt[1] & s_rvalid;
    assign if_rdata   = rd_tgt ? gpio_rdata : sram_rdata;
    assign d_rdata    = if_rdata;
    assign if_rresp   = rd_tgt ? gpio_rresp : sram_rresp;
    assign d_rresp    = if_rresp;

    assign wr_done = s_bvalid & m_bready;
    assign rd_done = s_rvalid & m_rready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_gnt  <= 2'b00;
            wr_last <= 1'b1;
            wr_tgt  <= 1'b0;
        end else if (wr_gnt == 2'b00) begin
            if (if_awvalid || d_awvalid) begin
                wr_gnt  <= wr_win ? 2'b10 : 2'b01;
                wr_last <= wr_win;
                wr_tgt  <= wr_win ? d_awaddr[region_bit] : if_awaddr[region_bit];
            end
        end else if (wr_done) begin
            wr_gnt <= 2'b00;                // channel idle from the next cycle
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_gnt  <= 2'b00;
            rd_last <= 1'b1;
            rd_tgt  <= 1'b0;
        end else if (rd_gnt == 2'b00) begin
            if (if_arvalid || d_arvalid) begin
                rd_gnt  <= rd_win ? 2'b10 : 2'b01;
                rd_last <= rd_win;
                rd_tgt  <= rd_win ? d_araddr[region_bit] : if_araddr[region_bit];
            end
        end else if (rd_done) begin
            rd_gnt <= 2'b00;
        end
    end

endmodule

`default_nettype wire

/* rtl/axil_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_sram
    import soc_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    input  logic [addr_w-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [data_w-1:0] wdata,
    input  logic [strb_w-1:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [resp_w-1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [addr_w-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [data_w-1:0] rdata,
    output logic [resp_w-1:0] rresp,
    output logic rvalid,
    input  logic rready
);

    logic [data_w-1:0] mem [sram_words];
    logic [sram_idx_w-1:0] wr_idx;
    logic [sram_idx_w-1:0] rd_idx;
    logic wr_go;
    logic rd_go;

    // word index, upper offsets alias
    assign wr_idx = awaddr[sram_idx_w+1:2];
    assign rd_idx = araddr[sram_idx_w+1:2];

    assign wr_go   = awvalid & wvalid & ~bvalid;    // address and data move together
    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = ~rvalid;
    assign rd_go   = arvalid & arready;

    assign bresp = resp_okay;
    assign rresp = resp_okay;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_go) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_go) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            for (int b = 0; b < strb_w; b++) begin
                if (wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        if (rd_go) begin
            rdata <= mem[rd_idx];               // held until the next accepted read
        end
    end

endmodule

`default_nettype wire

/* rtl/axil_gpio.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_gpio
    import soc_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    input  logic [addr_w-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [data_w-1:0] wdata,
    input  logic [strb_w-1:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [resp_w-1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [addr_w-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [data_w-1:0] rdata,
    output logic [resp_w-1:0] rresp,
    output logic rvalid,
    input  logic rready,
    output logic [soc_pkg::gpio_outputs-1:0] gpio_outputs
);

    logic wr_go;
    logic rd_go;
    logic wr_hit;
    logic rd_hit;

    // only offset 0 is mapped
    assign wr_hit = awaddr == gpio_base;
    assign rd_hit = araddr == gpio_base;

    assign wr_go   = awvalid & wvalid & ~bvalid;
    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = ~rvalid;
    assign rd_go   = arvalid & arready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid       <= 1'b0;
            rvalid       <= 1'b0;
            gpio_outputs <= '0;
        end else begin
            if (wr_go) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_go) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_go && wr_hit && wstrb[0]) begin
                gpio_outputs <= wdata[soc_pkg::gpio_outputs-1:0];   // low bits of byte 0
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            bresp <= wr_hit ? resp_okay : resp_slverr;
        end
        if (rd_go) begin
            rdata <= rd_hit ? data_w'(gpio_outputs) : '0;
            rresp <= rd_hit ? resp_okay : resp_slverr;
        end
    end

endmodule

`default_nettype wire

/* rtl/basic_soc.sv */
`timescale 1ns/1ps
`default_nettype none

module basic_soc
    import soc_pkg::*;
(
    input  logic clk,
    input  logic arst_n,

    // instruction-fetch master
    input  logic [addr_w-1:0] if_awaddr,
    input  logic if_awvalid,
    output logic if_awready,
    input  logic [data_w-1:0] if_wdata,
    input  logic [strb_w-1:0] if_wstrb,
    input  logic if_wvalid,
    output logic if_wready,
    output logic [resp_w-1:0] if_bresp,
    output logic if_bvalid,
    input  logic if_bready,
    input  logic [addr_w-1:0] if_araddr,
    input  logic if_arvalid,
    output logic if_arready,
    output logic [data_w-1:0] if_rdata,
    output logic [resp_w-1:0] if_rresp,
    output logic if_rvalid,
    input  logic if_rready,

    // data master
    input  logic [addr_w-1:0] d_awaddr,
    input  logic d_awvalid,
    output logic d_awready,
    input  logic [data_w-1:0] d_wdata,
    input  logic [strb_w-1:0] d_wstrb,
    input  logic d_wvalid,
    output logic d_wready,
    output logic [resp_w-1:0] d_bresp,
    output logic d_bvalid,
    input  logic d_bready,
    input  logic [addr_w-1:0] d_araddr,
    input  logic d_arvalid,
    output logic d_arready,
    output logic [data_w-1:0] d_rdata,
    output logic [resp_w-1:0] d_rresp,
    output logic d_rvalid,
    input  logic d_rready,

    output logic [soc_pkg::gpio_outputs-1:0] gpio_outputs
);

    // device side of the fabric
    logic [addr_w-1:0] sram_awaddr, sram_araddr, gpio_awaddr, gpio_araddr;
    logic [data_w-1:0] sram_wdata, sram_rdata, gpio_wdata, gpio_rdata;
    logic [strb_w-1:0] sram_wstrb, gpio_wstrb;
    logic [resp_w-1:0] sram_bresp, sram_rresp, gpio_bresp, gpio_rresp;
    logic sram_awvalid, sram_awready, sram_wvalid, sram_wready, sram_bvalid, sram_bready;
    logic sram_arvalid, sram_arready, sram_rvalid, sram_rready;
    logic gpio_awvalid, gpio_awready, gpio_wvalid, gpio_wready, gpio_bvalid, gpio_bready;
    logic gpio_arvalid, gpio_arready, gpio_rvalid, gpio_rready;

    axil_interconnect sys_bus (.*);

    axil_sram sram (
        .clk,
        .arst_n,
        .awaddr  (sram_awaddr),
        .awvalid (sram_awvalid),
        .awready (sram_awready),
        .wdata   (sram_wdata),
        .wstrb   (sram_wstrb),
        .wvalid  (sram_wvalid),
        .wready  (sram_wready),
        .bresp   (sram_bresp),
        .bvalid  (sram_bvalid),
        .bready  (sram_bready),
        .araddr  (sram_araddr),
        .arvalid (sram_arvalid),
        .arready (sram_arready),
        .rdata   (sram_rdata),
        .rresp   (sram_rresp),
        .rvalid  (sram_rvalid),
        .rready  (sram_rready)
    );

    axil_gpio gpio (
        .clk,
        .arst_n,
        .awaddr  (gpio_awaddr),
        .awvalid (gpio_awvalid),
        .awready (gpio_awready),
        .wdata   (gpio_wdata),
        .wstrb   (gpio_wstrb),
        .wvalid  (gpio_wvalid),
        .wready  (gpio_wready),
        .bresp   (gpio_bresp),
        .bvalid  (gpio_bvalid),
        .bready  (gpio_bready),
        .araddr  (gpio_araddr),
        .arvalid (gpio_arvalid),
        .arready (gpio_arready),
        .rdata   (gpio_rdata),
        .rresp   (gpio_rresp),
        .rvalid  (gpio_rvalid),
        .rready  (gpio_rready),
        .gpio_outputs
    );

endmodule

`default_nettype wire

/* bench/basic_soc_props.sv */
`timescale 1ns/1ps
`default_nettype none

module basic_soc_props
    import soc_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input logic if_awvalid, if_awready, if_wready, if_bvalid, if_bready,
    input logic if_arvalid, if_arready, if_rvalid, if_rready,
    input logic d_awvalid, d_awready, d_wready, d_bvalid, d_bready,
    input logic d_arvalid, d_arready, d_rvalid, d_rready,
    input logic [resp_w-1:0] if_bresp, if_rresp, d_bresp, d_rresp,
    input logic [data_w-1:0] if_rdata, d_rdata,
    input logic [soc_pkg::gpio_outputs-1:0] gpio_outputs
);

    logic [3:0][4:0] wait_cnt;          // cycles each request has waited for ready
    logic [3:0] waiting;

    assign waiting = {d_awvalid & ~d_awready, d_arvalid & ~d_arready,
                      if_awvalid & ~if_awready, if_arvalid & ~if_arready};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                wait_cnt[i] <= waiting[i] ? wait_cnt[i] + 5'd1 : 5'd0;
            end
        end
    end

    assert property (@(posedge clk) !arst_n |-> gpio_outputs == '0 &&
        !(if_bvalid | if_rvalid | d_bvalid | d_rvalid | if_awready | if_arready |
          d_awready | d_arready))
        else $error("outputs not cleared while arst_n is low");

    assert property (@(posedge clk) if_awready == if_wready && d_awready == d_wready)
        else $error("awready and wready differ on a master");

    // responses held under back-pressure
    assert property (@(posedge clk) disable iff (!arst_n)
        if_rvalid && !if_rready |=> if_rvalid && $stable(if_rdata) && $stable(if_rresp))
        else $error("if_ read response changed before its handshake");
    assert property (@(posedge clk) disable iff (!arst_n)
        d_rvalid && !d_rready |=> d_rvalid && $stable(d_rdata) && $stable(d_rresp))
        else $error("d_ read response changed before its handshake");
    assert property (@(posedge clk) disable iff (!arst_n)
        if_bvalid && !if_bready |=> if_bvalid && $stable(if_bresp))
        else $error("if_ write response changed before its handshake");
    assert property (@(posedge clk) disable iff (!arst_n)
        d_bvalid && !d_bready |=> d_bvalid && $stable(d_bresp))
        else $error("d_ write response changed before its handshake");

    assert property (@(posedge clk) disable iff (!arst_n)
        wait_cnt[0] < 5'd20 && wait_cnt[1] < 5'd20 && wait_cnt[2] < 5'd20 &&
        wait_cnt[3] < 5'd20)
        else $error("a request waited 20 cycles without being accepted");

endmodule

bind basic_soc basic_soc_props props (.*);

`default_nettype wire

/* bench/basic_soc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module basic_soc_tb
    import soc_pkg::*;
();

    logic clk;
    logic arst_n;
    logic [addr_w-1:0] if_awaddr, if_araddr, d_awaddr, d_araddr;
    logic [data_w-1:0] if_wdata, if_rdata, d_wdata, d_rdata;
    logic [strb_w-1:0] if_wstrb, d_wstrb;
    logic [resp_w-1:0] if_bresp, if_rresp, d_bresp, d_rresp;
    logic if_awvalid, if_awready, if_wvalid, if_wready, if_bvalid, if_bready;
    logic if_arvalid, if_arready, if_rvalid, if_rready;
    logic d_awvalid, d_awready, d_wvalid, d_wready, d_bvalid, d_bready;
    logic d_arvalid, d_arready, d_rvalid, d_rready;
    logic [soc_pkg::gpio_outputs-1:0] gpio_outputs;

    logic [data_w-1:0] shadow_mem [sram_words];     // expected SRAM contents
    logic [soc_pkg::gpio_outputs-1:0] shadow_gpio;
    int seed;
    int cycles = 0;
    bit hold_resp;                                  // random rready/bready stalls when set

    basic_soc DUT (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == 3000) begin               // about 200 transactions under 15 cycles
            $display("timeout: the tests did not finish within 3000 clock cycles");
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [data_w-1:0] got,
                               input logic [data_w-1:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s expected 0x%h, got 0x%h", name, exp, got);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // holds arst_n low for five clock edges
    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    // keeps the response ready low for a few cycles
    task automatic hold_off();
        int n;
        n = hold_resp ? ($random(seed) & 7) : 0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    function automatic logic [addr_w-1:0] sram_addr(input logic [4:0] word,
                                                   input logic [4:0] hi);
        return {1'b0, hi, 3'b000, word, 2'b00};     // hi lands above bit 9 and aliases
    endfunction

    task automatic write_txn(input bit m, input logic [addr_w-1:0] addr,
                             input logic [data_w-1:0] data, input logic [strb_w-1:0] strb);
        string pre;
        logic [resp_w-1:0] exp_resp;
        pre = m ? "d_" : "if_";
        exp_resp = (addr[region_bit] && addr != gpio_base) ? resp_slverr : resp_okay;
        if (m) begin
            {d_awaddr, d_wdata, d_wstrb} = {addr, data, strb};
            {d_awvalid, d_wvalid} = 2'b11;
        end else begin
            {if_awaddr, if_wdata, if_wstrb} = {addr, data, strb};
            {if_awvalid, if_wvalid} = 2'b11;
        end
        @(negedge clk);
        while (!(m ? d_awready : if_awready)) @(negedge clk);
        @(posedge clk);
        #1;
        if (m) {d_awvalid, d_wvalid} = 2'b00;
        else {if_awvalid, if_wvalid} = 2'b00;
        // the pins moved on the transfer edge and the model follows here
        if (!addr[region_bit]) begin
            for (int b = 0; b < strb_w; b++) begin
                if (strb[b]) shadow_mem[addr[9:2]][8*b +: 8] = data[8*b +: 8];
            end
        end else if (addr == gpio_base && strb[0]) begin
            shadow_gpio = data[soc_pkg::gpio_outputs-1:0];
        end
        hold_off();
        if (m) d_bready = 1'b1;
        else if_bready = 1'b1;
        @(negedge clk);
        while (!(m ? d_bvalid : if_bvalid)) @(negedge clk);
        check_value({pre, "bresp"}, data_w'(m ? d_bresp : if_bresp), data_w'(exp_resp));
        check_value("gpio_outputs", data_w'(gpio_outputs), data_w'(shadow_gpio));
        @(posedge clk);
        #1;
        if (m) d_bready = 1'b0;
        else if_bready = 1'b0;
    endtask

    task automatic read_txn(input bit m, input logic [addr_w-1:0] addr);
        string pre;
        logic [data_w-1:0] exp_data;
        logic [resp_w-1:0] exp_resp;
        pre = m ? "d_" : "if_";
        exp_data = '0;                          // unmapped gpio offset
        exp_resp = resp_slverr;
        if (!addr[region_bit]) begin
            exp_data = shadow_mem[addr[9:2]];
            exp_resp = resp_okay;
        end else if (addr == gpio_base) begin
            exp_data = data_w'(shadow_gpio);
            exp_resp = resp_okay;
        end
        if (m) {d_araddr, d_arvalid} = {addr, 1'b1};
        else {if_araddr, if_arvalid} = {addr, 1'b1};
        @(negedge clk);
        while (!(m ? d_arready : if_arready)) @(negedge clk);
        @(posedge clk);
        #1;
        if (m) d_arvalid = 1'b0;
        else if_arvalid = 1'b0;
        hold_off();
        if (m) d_rready = 1'b1;
        else if_rready = 1'b1;
        @(negedge clk);
        while (!(m ? d_rvalid : if_rvalid)) @(negedge clk);
        check_value({pre, "rdata"}, m ? d_rdata : if_rdata, exp_data);
        check_value({pre, "rresp"}, data_w'(m ? d_rresp : if_rresp), data_w'(exp_resp));
        @(posedge clk);
        #1;
        if (m) d_rready = 1'b0;
        else if_rready = 1'b0;
    endtask

    // random mix on one master
    // if_ owns words 0-15 and d_ owns 16-31 plus the gpio register
    task automatic traffic(input bit m, input int n);
        logic [31:0] r;
        logic [addr_w-1:0] gpio_addr;
        repeat (n) begin
            r = $random(seed);
            gpio_addr = m ? gpio_base : {1'b1, r[14:3], 1'b1, r[1:0]};
            case (r[17:16])
                2'd0: write_txn(m, sram_addr({m, r[5:2]}, r[10:6]), $random(seed), r[23:20]);
                2'd1: read_txn(m, sram_addr({m, r[5:2]}, r[10:6]));
                2'd2: write_txn(m, gpio_addr, $random(seed), r[23:20]);
                default: read_txn(m, gpio_addr);
            endcase
        end
    endtask

    initial begin
        logic [31:0] r;
        seed = 6;
        clk = 1'b0;
        arst_n = 1'b1;
        {if_awaddr, if_wdata, if_wstrb, if_araddr} = '0;
        {d_awaddr, d_wdata, d_wstrb, d_araddr} = '0;
        {if_awvalid, if_wvalid, if_bready, if_arvalid, if_rready} = '0;
        {d_awvalid, d_wvalid, d_bready, d_arvalid, d_rready} = '0;
        shadow_gpio = '0;
        hold_resp = 1'b0;
        #1;
        apply_reset();

        // fill the words that reads target later
        for (int w = 0; w < 32; w++) begin
            write_txn(w[0], sram_addr(5'(w), 5'd0), $random(seed), 4'hf);
        end
        repeat (40) begin
            r = $random(seed);
            write_txn(r[0], sram_addr(r[5:1], r[10:6]), $random(seed), r[14:11]);
            read_txn(r[15], sram_addr(r[5:1], r[20:16]));
        end

        // output register then nonzero offsets
        repeat (12) begin
            r = $random(seed);
            write_txn(r[0], gpio_base, $random(seed), r[7:4]);
            read_txn(r[1], gpio_base);
            write_txn(r[2], {1'b1, r[22:11], 1'b1, r[9:8]}, $random(seed), r[15:12]);
            read_txn(r[3], {1'b1, r[30:19], 1'b1, r[17:16]});
        end

        // reset with the pins set and a read response pending
        write_txn(1'b1, gpio_base, 32'h0000_000f, 4'h1);
        {d_araddr, d_arvalid} = {gpio_base, 1'b1};
        @(negedge clk);
        while (!d_arready) @(negedge clk);
        @(posedge clk);
        #1;
        d_arvalid = 1'b0;
        apply_reset();
        shadow_gpio = '0;

        // both masters together with response stalls in the second round
        repeat (2) begin
            fork
                traffic(1'b0, 30);
                traffic(1'b1, 30);
            join
            hold_resp = 1'b1;
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
rtl/soc_pkg.sv
rtl/axil_interconnect.sv
rtl/axil_sram.sv
rtl/axil_gpio.sv
rtl/basic_soc.sv
bench/basic_soc_props.sv
bench/basic_soc_tb.sv

/* run.sh */
#!/bin/sh
# a failed build or a nonzero exit from the model also marks sim.log as failed
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module basic_soc_tb -f flist.f > build.log 2>&1 &&
    ./obj_dir/Vbasic_soc_tb > sim.log 2>&1 ||
    echo "Simulation failed" >> sim.log
cat sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
